// ==== vlog.f ====
rtl/dbus_pkg.sv
rtl/cbus_pkg.sv
rtl/tag_store.sv
rtl/plru_tree.sv
rtl/line_store.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
verification/mem_model.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f vlog.f -o dcache_sim

output=$(./obj_dir/dcache_sim)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== verification/dcache_tb.sv ====
`default_nettype none

module dcache_tb;
    localparam int NUM_WAYS = 4;
    localparam int INDEX_BITS = 2;
    localparam int OFFSET_BITS = 2;
    localparam int NUM_SETS = 2 ** INDEX_BITS;
    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam int LINE_BITS = OFFSET_BITS + 2;
    localparam int LINE_BYTES = 2 ** LINE_BITS;
    localparam int SET_STRIDE = LINE_BYTES * NUM_SETS;
    localparam int MEM_WORDS = 4096;
    localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);
    localparam int MAX_CYCLES = 20000;

    logic clk;
    logic resetn;
    dbus_pkg::dbus_req_t dbus_req;
    dbus_pkg::dbus_resp_t dbus_resp;
    cbus_pkg::cbus_req_t cbus_req;
    cbus_pkg::cbus_resp_t cbus_resp;

    // reference model state
    dbus_pkg::word_t ref_mem [MEM_WORDS];
    bit ref_tree [NUM_SETS][NUM_WAYS-1];
    int ref_tag [NUM_SETS][NUM_WAYS];
    bit ref_valid [NUM_SETS][NUM_WAYS];
    bit ref_dirty [NUM_SETS][NUM_WAYS];
    int exp_reads;
    int exp_writes;
    dbus_pkg::addr_t exp_wb_addr;

    int errors;
    int tests_passed;
    int tests_failed;
    int cycles;
    int valid_cycles;

    dcache #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_BITS(INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) dut (
        .clk(clk), .resetn(resetn), .dbus_req(dbus_req), .dbus_resp(dbus_resp),
        .cbus_req(cbus_req), .cbus_resp(cbus_resp)
    );

    mem_model #(
        .MEM_WORDS(MEM_WORDS),
        .LINE_WORDS(2 ** OFFSET_BITS)
    ) mem (
        .clk(clk), .resetn(resetn), .cbus_req(cbus_req), .cbus_resp(cbus_resp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(negedge clk)
        if (cbus_req.valid)
            valid_cycles++;

    function automatic int word_index(dbus_pkg::addr_t addr);
        return int'(addr[2 +: MEM_IDX_BITS]);
    endfunction

    function automatic dbus_pkg::word_t initial_word(int idx);
        return dbus_pkg::word_t'(idx) * 32'h9e37_79b1 ^ 32'h0f1e_2d3c;
    endfunction

    function automatic dbus_pkg::addr_t line_addr(int tag, int set_idx, int word);
        return dbus_pkg::addr_t'(tag * SET_STRIDE + set_idx * LINE_BYTES + word * 4);
    endfunction

    // tree walk from the root, a zero bit goes left
    function automatic int plru_victim(int set_idx);
        int node;
        int way;
        node = 0;
        way = 0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            way = way * 2 + int'(ref_tree[set_idx][node]);
            node = 2 * node + 1 + int'(ref_tree[set_idx][node]);
        end
        return way;
    endfunction

    function automatic void plru_touch(int set_idx, int way);
        int node;
        int b;
        node = 0;
        for (int lvl = WAY_BITS - 1; lvl >= 0; lvl--) begin
            b = (way >> lvl) & 1;
            ref_tree[set_idx][node] = (b == 0);
            node = 2 * node + 1 + b;
        end
    endfunction

    // predicts bursts for one access and updates the model
    function automatic void model_access(dbus_pkg::addr_t addr, bit is_write);
        int set_idx;
        int tag;
        int way;
        set_idx = int'(addr[LINE_BITS +: INDEX_BITS]);
        tag = int'(addr >> (LINE_BITS + INDEX_BITS));
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++)
            if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag)
                way = w;
        if (way < 0) begin
            way = plru_victim(set_idx);
            if (ref_valid[set_idx][way] && ref_dirty[set_idx][way]) begin
                exp_writes++;
                exp_wb_addr = line_addr(ref_tag[set_idx][way], set_idx, 0);
            end
            exp_reads++;
            ref_valid[set_idx][way] = 1'b1;
            ref_dirty[set_idx][way] = 1'b0;
            ref_tag[set_idx][way] = tag;
        end
        if (is_write)
            ref_dirty[set_idx][way] = 1'b1;
        plru_touch(set_idx, way);
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // one request from issue to data_ok, entered and left just after a rising edge
    task automatic access(input bit is_write, input dbus_pkg::addr_t addr,
                          input dbus_pkg::wrten_t wrten, input dbus_pkg::word_t wdata,
                          output dbus_pkg::word_t rdata);
        logic taken;
        dbus_req.req = 1'b1;
        dbus_req.is_write = is_write;
        dbus_req.addr = addr;
        dbus_req.wrten = wrten;
        dbus_req.data = wdata;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = dbus_resp.addr_ok;
            @(posedge clk);
            #1;
        end
        dbus_req = '0;
        @(negedge clk);
        if (!dbus_resp.data_ok)
            flag_error($sformatf("no data_ok one cycle after accepting %h", addr));
        rdata = dbus_resp.data;
        @(posedge clk);
        #1;
    endtask

    task automatic read_check(input dbus_pkg::addr_t addr);
        dbus_pkg::word_t got;
        dbus_pkg::word_t expected;
        expected = ref_mem[word_index(addr)];
        model_access(addr, 1'b0);
        access(1'b0, addr, '0, '0, got);
        if (got !== expected)
            flag_error($sformatf("read %h returned %h, expected %h", addr, got, expected));
    endtask

    task automatic write_word(input dbus_pkg::addr_t addr, input dbus_pkg::wrten_t wrten,
                              input dbus_pkg::word_t data);
        dbus_pkg::word_t ignored;
        int idx;
        idx = word_index(addr);
        for (int b = 0; b < 4; b++)
            if (wrten[b])
                ref_mem[idx][8*b +: 8] = data[8*b +: 8];
        model_access(addr, 1'b1);
        access(1'b1, addr, wrten, data, ignored);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (mem.read_bursts != exp_reads || mem.write_bursts != exp_writes)
            flag_error($sformatf("%s: %0d read and %0d write bursts, model has %0d and %0d",
                name, mem.read_bursts, mem.write_bursts, exp_reads, exp_writes));
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic cold_read_miss();
        int e0;
        int r0;
        e0 = errors;
        r0 = mem.read_bursts;
        read_check(line_addr(1, 0, 0));
        if (mem.read_bursts != r0 + 1)
            flag_error($sformatf("%0d read bursts for one miss", mem.read_bursts - r0));
        if (mem.last_read_len != 3)
            flag_error($sformatf("refill len %0d, expected 3", mem.last_read_len));
        finish_test("cold_read_miss", e0);
    endtask

    task automatic read_hit();
        int e0;
        int v0;
        e0 = errors;
        v0 = valid_cycles;
        for (int w = 1; w <= 4; w++)
            read_check(line_addr(1, 0, w % 4));
        if (valid_cycles != v0)
            flag_error($sformatf("cbus valid high %0d cycles on hits", valid_cycles - v0));
        finish_test("read_hit", e0);
    endtask

    task automatic byte_write_hit();
        int e0;
        int idx;
        e0 = errors;
        idx = word_index(line_addr(1, 0, 2));
        write_word(line_addr(1, 0, 2), 4'b0101, 32'haabb_ccdd);
        read_check(line_addr(1, 0, 2));
        if (mem.words[idx] !== initial_word(idx))
            flag_error($sformatf("memory word %0d changed before eviction", idx));
        finish_test("byte_write_hit", e0);
    endtask

    task automatic dirty_eviction();
        int e0;
        int w0;
        e0 = errors;
        w0 = mem.write_bursts;
        write_word(line_addr(0, 1, 2), 4'b1111, 32'h1234_5678);
        for (int t = 1; t <= 4; t++)
            read_check(line_addr(t, 1, 0));
        if (mem.write_bursts != w0 + 1)
            flag_error($sformatf("%0d write bursts, expected one", mem.write_bursts - w0));
        if (mem.last_write_addr !== exp_wb_addr)
            flag_error($sformatf("writeback to %h, expected %h",
                mem.last_write_addr, exp_wb_addr));
        if (mem.words[word_index(line_addr(0, 1, 2))] !== 32'h1234_5678)
            flag_error("written word missing from memory after writeback");
        read_check(line_addr(0, 1, 2));
        finish_test("dirty_eviction", e0);
    endtask

    task automatic clean_eviction_plru();
        int order [11] = '{0, 1, 2, 3, 0, 4, 1, 5, 2, 0, 3};
        int e0;
        int w0;
        e0 = errors;
        w0 = mem.write_bursts;
        foreach (order[i])
            read_check(line_addr(order[i], 2, i % 4));
        if (mem.write_bursts != w0)
            flag_error("write burst seen while evicting clean lines");
        finish_test("clean_eviction_plru", e0);
    endtask

    task automatic soak();
        int e0;
        int set_idx;
        dbus_pkg::addr_t addr;
        e0 = errors;
        for (int n = 0; n < 200; n++) begin
            set_idx = ($urandom % 2 == 0) ? 1 : 3;
            addr = line_addr(int'($urandom % 6), set_idx, int'($urandom % 4));
            if ($urandom % 3 == 0)
                write_word(addr, dbus_pkg::wrten_t'($urandom % 15 + 1), $urandom);
            else
                read_check(addr);
        end
        // walk every word the soak could touch
        for (int t = 0; t < 6; t++)
            for (int w = 0; w < 4; w++) begin
                read_check(line_addr(t, 1, w));
                read_check(line_addr(t, 3, w));
            end
        if (mem.bad_bursts != 0)
            flag_error($sformatf("%0d bursts not line aligned or wrong len", mem.bad_bursts));
        finish_test("soak", e0);
    endtask

    initial begin
        void'($urandom(41260));
        clk = 1'b0;
        resetn = 1'b1;
        dbus_req = '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles = 0;
        valid_cycles = 0;
        exp_reads = 0;
        exp_writes = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = initial_word(i);
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w] = 0;
            end
            for (int n = 0; n < NUM_WAYS - 1; n++)
                ref_tree[s][n] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b0;
        @(posedge clk);
        #1;
        cold_read_miss();
        read_hit();
        byte_write_hit();
        dirty_eviction();
        clean_eviction_plru();
        soak();
        $display("%0d tests ok, %0d tests failed, %0d failed checks",
            tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mem_model.sv ====
`default_nettype none

module mem_model #(
    parameter int MEM_WORDS = 4096,
    parameter int LINE_WORDS = 4
) (
    input  wire logic                 clk,
    input  wire logic                 resetn,
    input  wire cbus_pkg::cbus_req_t  cbus_req,
    output cbus_pkg::cbus_resp_t      cbus_resp
);
    localparam int IDX_BITS = $clog2(MEM_WORDS);

    dbus_pkg::word_t words [MEM_WORDS];

    // burst statistics, read by the testbench
    int read_bursts;
    int write_bursts;
    int bad_bursts;
    int last_read_len;
    dbus_pkg::addr_t last_write_addr;

    cbus_pkg::cbus_req_t req_seen;
    logic busy;
    logic is_write;
    dbus_pkg::addr_t base;
    int beat;
    int len;
    int gap;

    function automatic int word_index(dbus_pkg::addr_t addr, int beat_num);
        return int'(addr[2 +: IDX_BITS]) + beat_num;
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++)
            words[i] = dbus_pkg::word_t'(i) * 32'h9e37_79b1 ^ 32'h0f1e_2d3c;
        cbus_resp = '0;
        busy = 1'b0;
        read_bursts = 0;
        write_bursts = 0;
        bad_bursts = 0;
    end

    // request fields are stable in the middle of the cycle
    always @(negedge clk)
        req_seen = cbus_req;

    always @(posedge clk) begin
        #1;
        if (resetn) begin
            cbus_resp = '0;
            busy = 1'b0;
        end else begin
            if (cbus_resp.okay) begin
                // the cache took this word at the edge
                if (is_write)
                    words[word_index(base, beat)] = req_seen.wdata;
                cbus_resp = '0;
                if (beat == len) begin
                    busy = 1'b0;
                    if (is_write) begin
                        write_bursts++;
                        last_write_addr = base;
                    end else begin
                        read_bursts++;
                        last_read_len = len;
                    end
                end else begin
                    beat++;
                    gap = int'($urandom % 4);
                end
            end else if (!busy && req_seen.valid) begin
                busy = 1'b1;
                base = req_seen.addr;
                is_write = req_seen.is_write;
                len = int'(req_seen.len);
                beat = 0;
                gap = int'($urandom % 4);
                if (len != LINE_WORDS - 1 ||
                        (base & dbus_pkg::addr_t'(LINE_WORDS * 4 - 1)) != 0)
                    bad_bursts++;
            end
            // random wait before each okay
            if (busy) begin
                if (gap == 0) begin
                    cbus_resp.okay = 1'b1;
                    cbus_resp.last = beat == len;
                    cbus_resp.rdata = is_write ? '0 : words[word_index(base, beat)];
                end else begin
                    gap--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`default_nettype none

module dcache #(
    parameter int NUM_WAYS = 4,
    parameter int INDEX_BITS = 2,
    parameter int OFFSET_BITS = 2
) (
    input  wire logic                 clk,
    input  wire logic                 resetn,
    input  wire dbus_pkg::dbus_req_t  dbus_req,
    output dbus_pkg::dbus_resp_t      dbus_resp,
    output cbus_pkg::cbus_req_t       cbus_req,
    input  wire cbus_pkg::cbus_resp_t cbus_resp
);
    localparam int WAY_BITS  = $clog2(NUM_WAYS);
    localparam int LINE_BITS = OFFSET_BITS + 2;
    localparam int TAG_BITS  = $bits(dbus_pkg::addr_t) - INDEX_BITS - LINE_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [WAY_BITS-1:0] way_t;

    tag_t req_tag;
    index_t req_index;
    offset_t req_offset;

    // tag | index | word offset | byte
    assign req_tag    = dbus_req.addr[LINE_BITS + INDEX_BITS +: TAG_BITS];
    assign req_index  = dbus_req.addr[LINE_BITS +: INDEX_BITS];
    assign req_offset = dbus_req.addr[2 +: OFFSET_BITS];

    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_valid;
    logic victim_dirty;
    tag_t victim_tag;
    logic accept;
    logic install;
    way_t miss_way;
    logic fill_en;
    offset_t fill_offset;
    dbus_pkg::word_t fill_word;
    dbus_pkg::word_t wb_word;
    dbus_pkg::word_t rdata;
    logic addr_ok;
    logic data_ok;

    dcache_ctrl #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_BITS(INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) ctrl (
        .clk(clk), .resetn(resetn), .dbus_req(dbus_req),
        .addr_ok(addr_ok), .data_ok(data_ok), .hit(hit),
        .victim_way(victim_way), .victim_valid(victim_valid),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .accept(accept), .install(install), .miss_way(miss_way),
        .fill_en(fill_en), .fill_offset(fill_offset), .fill_word(fill_word),
        .wb_word(wb_word), .cbus_req(cbus_req), .cbus_resp(cbus_resp)
    );

    tag_store #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_BITS(INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) tags (
        .clk(clk), .resetn(resetn), .index(req_index), .tag(req_tag),
        .accept(accept), .is_write(dbus_req.is_write),
        .install(install), .install_way(miss_way),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_valid(victim_valid), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    plru_tree #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_BITS(INDEX_BITS)
    ) plru (
        .clk(clk), .resetn(resetn), .index(req_index),
        .touch(accept), .touch_way(hit_way), .victim_way(victim_way)
    );

    line_store #(
        .NUM_WAYS(NUM_WAYS),
        .INDEX_BITS(INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) lines (
        .clk(clk), .index(req_index), .offset(req_offset),
        .access_way(hit_way), .accept(accept), .wrten(dbus_req.wrten),
        .wdata(dbus_req.data), .rdata(rdata),
        .fill_en(fill_en), .fill_way(miss_way), .fill_offset(fill_offset),
        .fill_word(fill_word), .wb_word(wb_word)
    );

    assign dbus_resp.addr_ok = addr_ok;
    assign dbus_resp.data_ok = data_ok;
    assign dbus_resp.data    = rdata;

endmodule

`default_nettype wire

// ==== rtl/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl #(
    parameter int NUM_WAYS = 4,
    parameter int INDEX_BITS = 2,
    parameter int OFFSET_BITS = 2,
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int TAG_BITS = $bits(dbus_pkg::addr_t) - INDEX_BITS - OFFSET_BITS - 2
) (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire dbus_pkg::dbus_req_t    dbus_req,
    output logic                        addr_ok,
    output logic                        data_ok,
    input  wire logic                   hit,
    input  wire logic [WAY_BITS-1:0]    victim_way,
    input  wire logic                   victim_valid,
    input  wire logic                   victim_dirty,
    input  wire logic [TAG_BITS-1:0]    victim_tag,
    output logic                        accept,
    output logic                        install,
    output logic [WAY_BITS-1:0]         miss_way,
    output logic                        fill_en,
    output logic [OFFSET_BITS-1:0]      fill_offset,
    output dbus_pkg::word_t             fill_word,
    input  wire dbus_pkg::word_t        wb_word,
    output cbus_pkg::cbus_req_t         cbus_req,
    input  wire cbus_pkg::cbus_resp_t   cbus_resp
);
    localparam int NUM_WORDS = 2 ** OFFSET_BITS;
    localparam int LINE_BITS = OFFSET_BITS + 2;

    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        INSTALL
    } state_t;

    state_t state;
    offset_t word_cnt;
    tag_t victim_tag_q;
    dbus_pkg::addr_t line_addr;
    dbus_pkg::addr_t wb_addr;
    logic miss;
    logic burst_done;

    assign accept  = state == IDLE && dbus_req.req && hit;
    assign miss    = state == IDLE && dbus_req.req && !hit;
    assign addr_ok = accept;
    assign install = state == INSTALL;

    assign burst_done = cbus_resp.okay && cbus_resp.last;

    // victim line sits at the same index as the request
    assign wb_addr = {victim_tag_q, line_addr[LINE_BITS +: INDEX_BITS], {LINE_BITS{1'b0}}};

    // refill writes each word as it arrives
    assign fill_en     = state == REFILL && cbus_resp.okay;
    assign fill_offset = word_cnt;
    assign fill_word   = cbus_resp.rdata;

    always_comb begin
        cbus_req.valid    = state == WRITEBACK || state == REFILL;
        cbus_req.is_write = state == WRITEBACK;
        cbus_req.addr     = state == WRITEBACK ? wb_addr : line_addr;
        cbus_req.len      = cbus_pkg::cbus_len_t'(NUM_WORDS - 1);
        cbus_req.wdata    = wb_word;
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= IDLE;
            data_ok  <= 1'b0;
            word_cnt <= '0;
        end else begin
            data_ok <= accept;
            case (state)
                IDLE: begin
                    if (miss) begin
                        word_cnt <= '0;
                        state <= victim_valid && victim_dirty ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK, REFILL: begin
                    if (cbus_resp.okay)
                        word_cnt <= offset_t'(word_cnt + 1'b1);
                    if (burst_done)
                        state <= state == WRITEBACK ? REFILL : INSTALL;
                end
                INSTALL: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // miss context, captured once at detection
    always_ff @(posedge clk) begin
        if (miss) begin
            miss_way     <= victim_way;
            victim_tag_q <= victim_tag;
            line_addr    <= {dbus_req.addr[31:LINE_BITS], {LINE_BITS{1'b0}}};
        end
    end

    // the installed line must serve the request waiting for it
    hit_after_install: assert property (@(posedge clk) disable iff (resetn)
        install |=> hit);

    // processor keeps its request steady until addr_ok
    req_held_until_accept: assert property (@(posedge clk) disable iff (resetn)
        dbus_req.req && !addr_ok |=> $stable(dbus_req));

endmodule

`default_nettype wire

// ==== rtl/line_store.sv ====
`default_nettype none

module line_store #(
    parameter int NUM_WAYS = 4,
    parameter int INDEX_BITS = 2,
    parameter int OFFSET_BITS = 2,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  wire logic                   clk,
    input  wire logic [INDEX_BITS-1:0]  index,
    input  wire logic [OFFSET_BITS-1:0] offset,
    input  wire logic [WAY_BITS-1:0]    access_way,
    input  wire logic                   accept,
    input  wire dbus_pkg::wrten_t       wrten,
    input  wire dbus_pkg::word_t        wdata,
    output dbus_pkg::word_t             rdata,
    input  wire logic                   fill_en,
    input  wire logic [WAY_BITS-1:0]    fill_way,
    input  wire logic [OFFSET_BITS-1:0] fill_offset,
    input  wire dbus_pkg::word_t        fill_word,
    output dbus_pkg::word_t             wb_word
);
    localparam int NUM_SETS  = 2 ** INDEX_BITS;
    localparam int NUM_WORDS = 2 ** OFFSET_BITS;
    localparam int NUM_BYTES = $bits(dbus_pkg::wrten_t);

    dbus_pkg::word_t data [NUM_SETS][NUM_WAYS][NUM_WORDS];

    // processor port, read returns the word before this edge's write
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= data[index][access_way][offset];
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wrten[b])
                    data[index][access_way][offset][8*b +: 8] <= wdata[8*b +: 8];
            end
        end else if (fill_en) begin
            data[index][fill_way][fill_offset] <= fill_word;
        end
    end

    // writeback streams straight out of the array
    assign wb_word = data[index][fill_way][fill_offset];

endmodule

`default_nettype wire

// ==== rtl/plru_tree.sv ====
`default_nettype none

module plru_tree #(
    parameter int NUM_WAYS = 4,
    parameter int INDEX_BITS = 2,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic [INDEX_BITS-1:0] index,
    input  wire logic                  touch,
    input  wire logic [WAY_BITS-1:0]   touch_way,
    output logic [WAY_BITS-1:0]        victim_way
);
    localparam int NUM_SETS = 2 ** INDEX_BITS;

    typedef logic [NUM_WAYS-2:0] tree_t;

    tree_t [NUM_SETS-1:0] trees;
    tree_t cur;
    tree_t next_tree;

    assign cur = trees[index];

    // heap order, children of node n are 2n+1 and 2n+2
    always_comb begin : walk
        int node;
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            victim_way[WAY_BITS-1-lvl] = cur[node];
            node = 2 * node + 1 + int'(cur[node]);
        end
    end

    // point every node on the touched path away from it
    always_comb begin : update
        int node;
        node = 0;
        next_tree = cur;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            next_tree[node] = ~touch_way[WAY_BITS-1-lvl];
            node = 2 * node + 1 + int'(touch_way[WAY_BITS-1-lvl]);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn)
            trees <= '0;
        else if (touch)
            trees[index] <= next_tree;
    end

    // a way just touched is never the next victim of its set
    victim_not_touched: assert property (@(posedge clk) disable iff (resetn)
        touch |=> index != $past(index) || victim_way != $past(touch_way));

endmodule

`default_nettype wire

// ==== rtl/tag_store.sv ====
`default_nettype none

module tag_store #(
    parameter int NUM_WAYS = 4,
    parameter int INDEX_BITS = 2,
    parameter int OFFSET_BITS = 2,
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int TAG_BITS = $bits(dbus_pkg::addr_t) - INDEX_BITS - OFFSET_BITS - 2
) (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic [INDEX_BITS-1:0] index,
    input  wire logic [TAG_BITS-1:0]   tag,
    input  wire logic                  accept,
    input  wire logic                  is_write,
    input  wire logic                  install,
    input  wire logic [WAY_BITS-1:0]   install_way,
    output logic                       hit,
    output logic [WAY_BITS-1:0]        hit_way,
    input  wire logic [WAY_BITS-1:0]   victim_way,
    output logic                       victim_valid,
    output logic                       victim_dirty,
    output logic [TAG_BITS-1:0]        victim_tag
);
    localparam int NUM_SETS = 2 ** INDEX_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [WAY_BITS-1:0] way_t;

    tag_t tags [NUM_SETS][NUM_WAYS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty;
    logic [NUM_WAYS-1:0] hit_vec;

    // compare against every way of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid[index][w] && tags[index][w] == tag;
            if (hit_vec[w])
                hit_way = hit_way | way_t'(w);
        end
    end

    assign hit = |hit_vec;

    // state of the way the replacement picked
    assign victim_valid = valid[index][victim_way];
    assign victim_dirty = dirty[index][victim_way];
    assign victim_tag   = tags[index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
            dirty <= '0;
        end else if (install) begin
            valid[index][install_way] <= 1'b1;
            dirty[index][install_way] <= 1'b0;
        end else if (accept && is_write) begin
            dirty[index][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (install)
            tags[index][install_way] <= tag;
    end

    // a tag lives in at most one way of its set
    hit_onehot: assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== rtl/cbus_pkg.sv ====
`default_nettype none

package cbus_pkg;

    // burst length minus one
    typedef logic [3:0] cbus_len_t;

    // request fields stay constant from valid rising to the last okay
    typedef struct packed {
        logic             valid;
        logic             is_write;
        dbus_pkg::addr_t  addr;
        cbus_len_t        len;
        dbus_pkg::word_t  wdata;
    } cbus_req_t;

    // one okay per word, last marks the final one
    typedef struct packed {
        logic            okay;
        logic            last;
        dbus_pkg::word_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

// ==== rtl/dbus_pkg.sv ====
`default_nettype none

package dbus_pkg;

    // byte address and data word of the processor bus
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // one enable per byte lane, all zero on a read
    typedef logic [3:0] wrten_t;

    // processor request, held until addr_ok is seen at an edge
    typedef struct packed {
        logic   req;
        logic   is_write;
        addr_t  addr;
        wrten_t wrten;
        word_t  data;
    } dbus_req_t;

    // addr_ok is combinational, data_ok follows one cycle later
    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

endpackage

`default_nettype wire
